/* design/joybus_pkg.sv */
package joybus_pkg;

    // line timing, in sample_clk cycles at 100 ns
    localparam int samples_per_bit = 40;

    // a low phase at or above this length decodes as 0
    localparam int bit_threshold = 20;

    // this many high samples in a row end any frame
    localparam int idle_limit = 80;

    localparam int addr_bytes = 2;
    localparam int payload_bytes = 32;

    localparam int low_cnt_w = $clog2(samples_per_bit + 1);
    localparam int high_cnt_w = $clog2(idle_limit + 1);
    localparam int index_w = $clog2(payload_bytes);

    // data crc, zero seed, msb first
    localparam logic [7:0] crc_poly = 8'h85;

    // cmd value before any frame has been seen
    localparam logic [7:0] no_cmd = 8'hfe;

    typedef enum logic [7:0] {
        cmd_info   = 8'h00,
        cmd_status = 8'h01,
        cmd_read   = 8'h02,
        cmd_write  = 8'h03,
        cmd_reset  = 8'hff
    } joybus_cmd_e;

    typedef enum logic [2:0] {
        st_cmd,
        st_addr,
        st_payload,
        st_stop,
        st_drop
    } rx_state_e;

    // one decoded bit cell
    typedef struct packed {
        logic valid;
        logic value;
    } rx_bit_t;

    // one assembled byte
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } rx_byte_t;

endpackage

/* design/joybus_bit_decoder.sv */
`timescale 1ns/10ps

module joybus_bit_decoder
    import joybus_pkg::*;
(
    input  logic    sample_clk,
    input  logic    reset,
    input  logic    data_rx,
    input  logic    cur_operation,
    output rx_bit_t bit_out,
    output logic    line_idle
);

    logic [1:0]            sync_q;
    logic                  line_q;
    logic                  rise;
    logic [low_cnt_w-1:0]  low_cnt;
    logic [high_cnt_w-1:0] high_cnt;
    logic                  bit_valid_q;
    logic                  bit_value_q;

    // data_rx is asynchronous to sample_clk
    always_ff @(posedge sample_clk) begin
        if (reset) begin
            sync_q <= 2'b11;
            line_q <= 1'b1;
        end else begin
            sync_q <= {sync_q[0], data_rx};
            line_q <= sync_q[1];
        end
    end

    // end of a low phase
    assign rise = sync_q[1] & ~line_q;

    // low phase length saturates at one full cell
    always_ff @(posedge sample_clk) begin
        if (reset) begin
            low_cnt <= '0;
        end else if (sync_q[1]) begin
            low_cnt <= '0;
        end else if (low_cnt != low_cnt_w'(samples_per_bit)) begin
            low_cnt <= low_cnt + 1'b1;
        end
    end

    // the line counts as idle out of reset
    always_ff @(posedge sample_clk) begin
        if (reset) begin
            high_cnt <= high_cnt_w'(idle_limit);
        end else if (!sync_q[1]) begin
            high_cnt <= '0;
        end else if (high_cnt != high_cnt_w'(idle_limit)) begin
            high_cnt <= high_cnt + 1'b1;
        end
    end

    assign line_idle = (high_cnt == high_cnt_w'(idle_limit));

    always_ff @(posedge sample_clk) begin
        if (reset) begin
            bit_valid_q <= 1'b0;
        end else begin
            // own transmission is not decoded
            bit_valid_q <= rise & ~cur_operation;
        end
    end

    // short low means 1, long low means 0
    always_ff @(posedge sample_clk) begin
        if (rise) begin
            bit_value_q <= (low_cnt < low_cnt_w'(bit_threshold));
        end
    end

    assign bit_out = '{valid: bit_valid_q, value: bit_value_q};

    no_bit_while_tx: assert property (
        @(posedge sample_clk) disable iff (reset)
        cur_operation |-> !bit_out.valid
    );

endmodule

/* design/joybus_byte_shifter.sv */
`timescale 1ns/10ps

module joybus_byte_shifter
    import joybus_pkg::*;
(
    input  logic     sample_clk,
    input  logic     reset,
    input  logic     frame_clear,
    input  rx_bit_t  bit_in,
    output rx_byte_t byte_out
);

    logic [2:0] bit_cnt;
    logic [7:0] shift_q;
    logic       byte_valid_q;

    always_ff @(posedge sample_clk) begin
        if (reset) begin
            bit_cnt      <= '0;
            byte_valid_q <= 1'b0;
        end else if (frame_clear) begin
            bit_cnt      <= '0;
            byte_valid_q <= 1'b0;
        end else begin
            // byte is complete on the 8th bit
            byte_valid_q <= bit_in.valid && (bit_cnt == 3'd7);
            if (bit_in.valid) begin
                bit_cnt <= bit_cnt + 3'd1;
            end
        end
    end

    // msb arrives first
    always_ff @(posedge sample_clk) begin
        if (bit_in.valid) begin
            shift_q <= {shift_q[6:0], bit_in.value};
        end
    end

    assign byte_out = '{valid: byte_valid_q, data: shift_q};

endmodule

/* design/joybus_crc8.sv */
`timescale 1ns/10ps

module joybus_crc8
    import joybus_pkg::*;
(
    input  logic       sample_clk,
    input  logic       reset,
    input  logic       frame_clear,
    input  logic       crc_enable,
    input  rx_byte_t   byte_in,
    output logic [7:0] crc
);

    // eight serial steps, msb of the byte first
    function automatic logic [7:0] crc_byte(input logic [7:0] crc_in, input logic [7:0] data);
        logic [7:0] c;
        c = crc_in;
        for (int i = 7; i >= 0; i--) begin
            if (c[7] ^ data[i]) begin
                c = {c[6:0], 1'b0} ^ crc_poly;
            end else begin
                c = {c[6:0], 1'b0};
            end
        end
        return c;
    endfunction

    always_ff @(posedge sample_clk) begin
        if (reset) begin
            crc <= '0;
        end else if (frame_clear) begin
            crc <= '0;
        end else if (crc_enable && byte_in.valid) begin
            crc <= crc_byte(crc, byte_in.data);
        end
    end

endmodule

/* design/joybus_rx_ctrl.sv */
`timescale 1ns/10ps

module joybus_rx_ctrl
    import joybus_pkg::*;
(
    input  logic               sample_clk,
    input  logic               reset,
    input  rx_bit_t            bit_in,
    input  rx_byte_t           byte_in,
    input  logic               line_idle,
    output logic               frame_clear,
    output logic               crc_enable,
    output joybus_cmd_e        cmd,
    output logic [15:0]        address,
    output logic               wr_byte,
    output logic [7:0]         wr_data,
    output logic [index_w-1:0] wr_index,
    output logic               tx_handoff
);

    rx_state_e          state;
    logic [index_w-1:0] byte_idx;
    logic [7:0]         addr_hi;
    logic               idle_q;
    logic               idle_rise;

    assign idle_rise = line_idle & ~idle_q;

    always_ff @(posedge sample_clk) begin
        if (reset) begin
            state       <= st_cmd;
            byte_idx    <= '0;
            cmd         <= joybus_cmd_e'(no_cmd);
            address     <= '0;
            frame_clear <= 1'b0;
            crc_enable  <= 1'b0;
            wr_byte     <= 1'b0;
            tx_handoff  <= 1'b0;
            idle_q      <= 1'b1;
        end else begin
            frame_clear <= 1'b0;
            wr_byte     <= 1'b0;
            idle_q      <= line_idle;
            case (state)
                st_cmd: begin
                    if (byte_in.valid) begin
                        cmd      <= joybus_cmd_e'(byte_in.data);
                        byte_idx <= '0;
                        case (joybus_cmd_e'(byte_in.data))
                            cmd_info, cmd_status, cmd_reset: state <= st_stop;
                            cmd_read, cmd_write:             state <= st_addr;
                            default:                         state <= st_drop;
                        endcase
                    end else if (idle_rise) begin
                        // flush a partial command byte
                        frame_clear <= 1'b1;
                    end
                end
                st_addr: begin
                    if (line_idle) begin
                        state <= st_drop;
                    end else if (byte_in.valid) begin
                        if (byte_idx == index_w'(addr_bytes - 1)) begin
                            address  <= {addr_hi, byte_in.data};
                            byte_idx <= '0;
                            if (cmd == cmd_write) begin
                                state      <= st_payload;
                                crc_enable <= 1'b1;
                            end else begin
                                state <= st_stop;
                            end
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end
                end
                st_payload: begin
                    if (line_idle) begin
                        state      <= st_drop;
                        crc_enable <= 1'b0;
                    end else if (byte_in.valid) begin
                        wr_byte <= 1'b1;
                        if (byte_idx == index_w'(payload_bytes - 1)) begin
                            state      <= st_stop;
                            crc_enable <= 1'b0;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end
                end
                st_stop: begin
                    if (line_idle) begin
                        state <= st_drop;
                    end else if (bit_in.valid) begin
                        // hand the line over to the responder
                        tx_handoff  <= ~tx_handoff;
                        frame_clear <= 1'b1;
                        state       <= st_cmd;
                    end
                end
                st_drop: begin
                    if (line_idle) begin
                        frame_clear <= 1'b1;
                        state       <= st_cmd;
                    end
                end
                default: begin
                    state <= st_drop;
                end
            endcase
        end
    end

    // high address byte waits for the low one
    always_ff @(posedge sample_clk) begin
        if (state == st_addr && byte_in.valid && byte_idx == '0) begin
            addr_hi <= byte_in.data;
        end
    end

    always_ff @(posedge sample_clk) begin
        if (state == st_payload && byte_in.valid) begin
            wr_data  <= byte_in.data;
            wr_index <= byte_idx;
        end
    end

    wr_byte_from_payload: assert property (
        @(posedge sample_clk) disable iff (reset)
        wr_byte |-> $past(state) == st_payload
    );

    crc_only_in_payload: assert property (
        @(posedge sample_clk) disable iff (reset)
        crc_enable |-> state == st_payload
    );

endmodule

/* design/n64_controller_rx.sv */
`timescale 1ns/10ps

module n64_controller_rx
    import joybus_pkg::*;
(
    input  logic               sample_clk,
    input  logic               reset,
    input  logic               cur_operation,
    input  logic               data_rx,
    output logic               tx_handoff,
    output joybus_cmd_e        cmd,
    output logic [15:0]        address,
    output logic [7:0]         crc,
    output logic               wr_byte,
    output logic [7:0]         wr_data,
    output logic [index_w-1:0] wr_index
);

    rx_bit_t  rx_bit;
    rx_byte_t rx_byte;
    logic     line_idle;
    logic     frame_clear;
    logic     crc_enable;

    joybus_bit_decoder i_joybus_bit_decoder (
        .sample_clk    (sample_clk),
        .reset         (reset),
        .data_rx       (data_rx),
        .cur_operation (cur_operation),
        .bit_out       (rx_bit),
        .line_idle     (line_idle)
    );

    joybus_byte_shifter i_joybus_byte_shifter (
        .sample_clk  (sample_clk),
        .reset       (reset),
        .frame_clear (frame_clear),
        .bit_in      (rx_bit),
        .byte_out    (rx_byte)
    );

    // only write payload bytes are folded in
    joybus_crc8 i_joybus_crc8 (
        .sample_clk  (sample_clk),
        .reset       (reset),
        .frame_clear (frame_clear),
        .crc_enable  (crc_enable),
        .byte_in     (rx_byte),
        .crc         (crc)
    );

    joybus_rx_ctrl i_joybus_rx_ctrl (
        .sample_clk  (sample_clk),
        .reset       (reset),
        .bit_in      (rx_bit),
        .byte_in     (rx_byte),
        .line_idle   (line_idle),
        .frame_clear (frame_clear),
        .crc_enable  (crc_enable),
        .cmd         (cmd),
        .address     (address),
        .wr_byte     (wr_byte),
        .wr_data     (wr_data),
        .wr_index    (wr_index),
        .tx_handoff  (tx_handoff)
    );

endmodule

/* sim/joybus_line_tasks.svh */
// linear congruential generator for payloads and addresses
function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// drive data_rx to a level for a number of sample cycles
task automatic hold_line(input logic level, input int cycles);
    for (int i = 0; i < cycles; i++) begin
        @(posedge sample_clk);
        #10;
        data_rx = level;
    end
endtask

// one bit cell: long low for 0, short low for 1
task automatic send_bit(input logic value);
    if (value) begin
        hold_line(1'b0, 10);
        hold_line(1'b1, samples_per_bit - 10);
    end else begin
        hold_line(1'b0, samples_per_bit - 10);
        hold_line(1'b1, 10);
    end
endtask

task automatic send_stop();
    hold_line(1'b0, 10);
    hold_line(1'b1, 20);
endtask

// msb first on the wire
task automatic send_byte(input logic [7:0] data);
    for (int i = 7; i >= 0; i--) begin
        send_bit(data[i]);
    end
endtask

task automatic send_idle(input int cycles);
    hold_line(1'b1, cycles);
endtask

// command byte, optional address, payload from payload_data, stop bit
task automatic send_frame(
    input logic [7:0]  opcode,
    input bit          with_addr,
    input logic [15:0] addr,
    input int          n_payload
);
    send_byte(opcode);
    if (with_addr) begin
        send_byte(addr[15:8]);
        send_byte(addr[7:0]);
    end
    for (int i = 0; i < n_payload; i++) begin
        send_byte(payload_data[i]);
    end
    send_stop();
endtask

/* sim/tb_n64_controller_rx.sv */
`timescale 1ns/10ps

module tb_n64_controller_rx
    import joybus_pkg::*;
;

    localparam int toggle_timeout = 20000;
    localparam int gap_cycles = 120;

    logic               sample_clk;
    logic               reset;
    logic               cur_operation;
    logic               data_rx;
    logic               tx_handoff;
    joybus_cmd_e        cmd;
    logic [15:0]        address;
    logic [7:0]         crc;
    logic               wr_byte;
    logic [7:0]         wr_data;
    logic [index_w-1:0] wr_index;

    logic [7:0]  payload_data [payload_bytes];
    logic [31:0] rand_state;
    logic [15:0] rand_addr;
    int          errors;
    int          errors_at_start;
    int          tests;
    int          failed_tests;
    int          toggle_count;
    int          toggles_before;
    int          wr_count;
    bit          wr_allowed;
    logic        handoff_q;
    logic [7:0]  crc_at_toggle;
    logic [7:0]  cmd_at_toggle;
    logic [15:0] address_at_toggle;

    n64_controller_rx i_n64_controller_rx (
        .sample_clk    (sample_clk),
        .reset         (reset),
        .cur_operation (cur_operation),
        .data_rx       (data_rx),
        .tx_handoff    (tx_handoff),
        .cmd           (cmd),
        .address       (address),
        .crc           (crc),
        .wr_byte       (wr_byte),
        .wr_data       (wr_data),
        .wr_index      (wr_index)
    );

    `include "joybus_line_tasks.svh"

    initial begin
        sample_clk = 1'b0;
        forever #50 sample_clk = ~sample_clk;
    end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail %s expected 0x%0h got 0x%0h", name, exp, got);
            errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("Error: %s", msg);
        errors++;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: passed", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed", tests, name);
        end
        errors_at_start = errors;
    endtask

    task automatic wait_toggles(input int target);
        int cycles;
        cycles = 0;
        while (toggle_count < target && cycles < toggle_timeout) begin
            @(posedge sample_clk);
            cycles++;
        end
        if (toggle_count < target) begin
            report_error("timed out waiting for tx_handoff to toggle");
        end
    endtask

    task automatic fill_payload();
        for (int i = 0; i < payload_bytes; i++) begin
            rand_state = lcg_next(rand_state);
            payload_data[i] = rand_state[23:16];
        end
    endtask

    // data crc, byte folded into the register and then shifted out
    function automatic logic [7:0] crc_ref(input int n);
        logic [7:0] c;
        c = 8'h00;
        for (int i = 0; i < n; i++) begin
            c = c ^ payload_data[i];
            for (int b = 0; b < 8; b++) begin
                c = c[7] ? ((c << 1) ^ crc_poly) : (c << 1);
            end
        end
        return c;
    endfunction

    // outputs are sampled mid-cycle
    always @(negedge sample_clk) begin
        if (!reset) begin
            if (tx_handoff !== handoff_q) begin
                toggle_count++;
                crc_at_toggle     = crc;
                cmd_at_toggle     = cmd;
                address_at_toggle = address;
            end
            handoff_q = tx_handoff;
            if (wr_byte) begin
                assert (wr_allowed) else report_error("wr_byte pulsed outside a write frame");
                if (wr_allowed && wr_count < payload_bytes) begin
                    check_value("wr_data", wr_data, payload_data[wr_count]);
                    check_value("wr_index", wr_index, wr_count);
                end
                wr_count++;
            end
        end
    end

    task automatic run_short_frame(input logic [7:0] opcode);
        toggles_before = toggle_count;
        send_frame(opcode, 1'b0, 16'h0000, 0);
        wait_toggles(toggles_before + 1);
        check_value("cmd", cmd_at_toggle, opcode);
        send_idle(gap_cycles);
    endtask

    initial begin
        reset           = 1'b1;
        cur_operation   = 1'b0;
        data_rx         = 1'b1;
        rand_state      = 32'hca9d;
        errors          = 0;
        errors_at_start = 0;
        tests           = 0;
        failed_tests    = 0;
        toggle_count    = 0;
        wr_count        = 0;
        wr_allowed      = 1'b0;
        handoff_q       = 1'b0;
        repeat (8) @(posedge sample_clk);
        #10;
        reset = 1'b0;

        check_value("tx_handoff", tx_handoff, 1'b0);
        check_value("wr_byte", wr_byte, 1'b0);
        check_value("cmd", cmd, 8'hfe);
        end_test("reset values");

        run_short_frame(cmd_info);
        run_short_frame(cmd_status);
        run_short_frame(cmd_reset);
        end_test("info, status and reset frames");

        rand_state = lcg_next(rand_state);
        rand_addr  = rand_state[31:16];
        wr_count   = 0;
        toggles_before = toggle_count;
        send_frame(cmd_read, 1'b1, rand_addr, 0);
        wait_toggles(toggles_before + 1);
        check_value("cmd", cmd_at_toggle, cmd_read);
        check_value("address", address_at_toggle, rand_addr);
        send_idle(gap_cycles);
        check_value("wr_byte count", wr_count, 0);
        end_test("read frame");

        rand_state = lcg_next(rand_state);
        rand_addr  = rand_state[31:16];
        fill_payload();
        wr_count   = 0;
        wr_allowed = 1'b1;
        toggles_before = toggle_count;
        send_frame(cmd_write, 1'b1, rand_addr, payload_bytes);
        wait_toggles(toggles_before + 1);
        check_value("cmd", cmd_at_toggle, cmd_write);
        check_value("address", address_at_toggle, rand_addr);
        check_value("crc", crc_at_toggle, crc_ref(payload_bytes));
        send_idle(gap_cycles);
        wr_allowed = 1'b0;
        check_value("wr_byte count", wr_count, payload_bytes);
        end_test("write frame");

        // unknown command is dropped until the line goes idle
        toggles_before = toggle_count;
        send_byte(8'h55);
        send_stop();
        send_idle(gap_cycles);
        check_value("toggle count", toggle_count, toggles_before);
        send_frame(cmd_info, 1'b0, 16'h0000, 0);
        wait_toggles(toggles_before + 1);
        send_idle(gap_cycles);
        check_value("toggle count", toggle_count, toggles_before + 1);
        end_test("unknown command");

        @(posedge sample_clk);
        #10;
        cur_operation = 1'b1;
        fill_payload();
        wr_count = 0;
        toggles_before = toggle_count;
        send_frame(cmd_write, 1'b1, 16'h1234, payload_bytes);
        send_idle(gap_cycles);
        cur_operation = 1'b0;
        send_idle(gap_cycles);
        check_value("toggle count", toggle_count, toggles_before);
        check_value("wr_byte count", wr_count, 0);
        run_short_frame(cmd_status);
        end_test("line ignored while transmitting");

        $display("%0d tests, %0d failed, %0d check errors", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+sim
design/joybus_pkg.sv
design/joybus_bit_decoder.sv
design/joybus_byte_shifter.sv
design/joybus_crc8.sv
design/joybus_rx_ctrl.sv
design/n64_controller_rx.sv
sim/tb_n64_controller_rx.sv

/* Bender.yml */
package:
  name: n64_controller_rx

sources:
  - files:
      - design/joybus_pkg.sv
      - design/joybus_bit_decoder.sv
      - design/joybus_byte_shifter.sv
      - design/joybus_crc8.sv
      - design/joybus_rx_ctrl.sv
      - design/n64_controller_rx.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_n64_controller_rx.sv
